// ==== logic/lane_config_pkg.sv ====
// Lane configuration constants covering chain size, widths, buffer depths and engine states
`default_nettype none

package lane_config_pkg;

    // ------------------------------------------------------------------
    // Lane geometry
    // ------------------------------------------------------------------
    // Engines in the chain, every one of them a memory requester
    localparam int NUM_ENGINES = 4;
    // Enough bits to name any engine in a memory word
    localparam int ENGINE_ID_W = 2;

    // Value carried down the chain and the memory address built from it
    localparam int VALUE_W = 16;
    localparam int ADDR_W  = 16;

    // Per engine input buffer and shared request queue
    localparam int ENGINE_FIFO_DEPTH = 4;
    localparam int REQ_FIFO_DEPTH    = 4;

    // ------------------------------------------------------------------
    // Engine FSM encoding
    // ------------------------------------------------------------------
    localparam int                     ENG_STATE_W = 2;
    localparam logic [ENG_STATE_W-1:0] ENG_IDLE    = 2'd0;
    localparam logic [ENG_STATE_W-1:0] ENG_REQ     = 2'd1;
    localparam logic [ENG_STATE_W-1:0] ENG_WAIT    = 2'd2;
    localparam logic [ENG_STATE_W-1:0] ENG_FWD     = 2'd3;

endpackage : lane_config_pkg

`default_nettype wire

// ==== logic/mem_packet_pkg.sv ====
// Memory port word, read as a request on the way out and as a response on the way back
`default_nettype none

package mem_packet_pkg;

    import lane_config_pkg::*;

    // ------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------
    // Returned data, same width as the address so both views line up
    localparam int MEM_DATA_W = 16;
    localparam int MEM_WORD_W = ENGINE_ID_W + ADDR_W;

    // ------------------------------------------------------------------
    // Memory word
    // ------------------------------------------------------------------
    // ID on top in both views, so routing never depends on the view
    typedef union packed {
        // Outbound, engine ID and the read address
        struct packed {
            logic [ENGINE_ID_W-1:0] id;
            logic [ADDR_W-1:0]      addr;
        } req;
        // Inbound, engine ID echoed back with the read data
        struct packed {
            logic [ENGINE_ID_W-1:0] id;
            logic [MEM_DATA_W-1:0]  data;
        } rsp;
    } mem_word_u;

endpackage : mem_packet_pkg

`default_nettype wire

// ==== logic/lane_fifo.sv ====
// Synchronous circular FIFO with a full level and an empty flag
`timescale 1ns/10ps
`default_nettype none

module lane_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 4
) (
    input  logic             ap_clk,
    input  logic             areset_lane_template,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o,
    output logic             full_o
);

    // Storage, pointers and fill count
    logic [WIDTH-1:0]           mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    // ------------------------------------------------------------------
    // Pointer and count update
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap at DEPTH, which need not be a power of two
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload write
    always_ff @(posedge ap_clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Head word shows without a pop, valid while not empty
    assign pop_data_o = mem_q[rd_ptr_q];
    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == ($clog2(DEPTH+1))'(DEPTH));

    // Producer honors full, consumer honors empty
    a_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        !(push_i && full_o));
    a_no_underflow: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        !(pop_i && empty_o));

endmodule : lane_fifo

`default_nettype wire

// ==== logic/lane_engine.sv ====
// Chain engine that reads memory at base plus value and forwards value plus data
`timescale 1ns/10ps
`default_nettype none

module lane_engine import lane_config_pkg::*, mem_packet_pkg::*; #(
    parameter int ENGINE_ID = 0
) (
    input  logic                  ap_clk,
    input  logic                  areset_lane_template,
    input  logic                  in_push_i,
    input  logic [VALUE_W-1:0]    in_value_i,
    input  logic [ADDR_W-1:0]     base_i,
    input  logic                  req_grant_i,
    input  logic                  rsp_valid_i,
    input  logic [MEM_DATA_W-1:0] rsp_data_i,
    input  logic                  out_full_i,
    output logic                  in_full_o,
    output logic                  req_valid_o,
    output logic [ADDR_W-1:0]     req_addr_o,
    output logic                  out_valid_o,
    output logic [VALUE_W-1:0]    out_value_o,
    output logic                  idle_o
);

    logic [ENG_STATE_W-1:0] state_q;
    // Holds the input value, then the sum once the data is back
    logic [VALUE_W-1:0]     value_q;
    logic                   fifo_pop;
    logic [VALUE_W-1:0]     fifo_head;
    logic                   fifo_empty;

    // ------------------------------------------------------------------
    // Input buffer
    // ------------------------------------------------------------------
    lane_fifo #(
        .WIDTH (VALUE_W),
        .DEPTH (ENGINE_FIFO_DEPTH)
    ) u_in_fifo (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .push_i               (in_push_i),
        .push_data_i          (in_value_i),
        .pop_i                (fifo_pop),
        .pop_data_o           (fifo_head),
        .empty_o              (fifo_empty),
        .full_o               (in_full_o)
    );

    // One item in flight, so only an idle engine takes the next one
    assign fifo_pop = (state_q == ENG_IDLE) && !fifo_empty;

    // ------------------------------------------------------------------
    // Request, wait, forward FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state_q <= ENG_IDLE;
        end else begin
            case (state_q)
                ENG_IDLE: if (fifo_pop)     state_q <= ENG_REQ;
                ENG_REQ:  if (req_grant_i)  state_q <= ENG_WAIT;
                // Response latency is open ended
                ENG_WAIT: if (rsp_valid_i)  state_q <= ENG_FWD;
                // Fires on the first cycle downstream has room
                ENG_FWD:  if (!out_full_i)  state_q <= ENG_IDLE;
                default:                    state_q <= ENG_IDLE;
            endcase
        end
    end

    // Payload, sum wraps at VALUE_W
    always_ff @(posedge ap_clk) begin
        if (fifo_pop) begin
            value_q <= fifo_head;
        end else if ((state_q == ENG_WAIT) && rsp_valid_i) begin
            value_q <= value_q + VALUE_W'(rsp_data_i);
        end
    end

    // Request held until the grant bit shows
    assign req_valid_o = (state_q == ENG_REQ);
    assign req_addr_o  = base_i + ADDR_W'(value_q);

    assign out_valid_o = (state_q == ENG_FWD) && !out_full_i;
    assign out_value_o = value_q;
    assign idle_o      = (state_q == ENG_IDLE) && fifo_empty;

    // Routed responses only ever reach an engine that is waiting for one
    a_rsp_in_wait: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        rsp_valid_i |-> (state_q == ENG_WAIT))
        else $error("engine %0d saw a response outside the wait state", ENGINE_ID);

endmodule : lane_engine

`default_nettype wire

// ==== logic/mem_port_arbiter.sv ====
// Round-robin request arbiter with a request queue, and ID based response routing
`timescale 1ns/10ps
`default_nettype none

module mem_port_arbiter import lane_config_pkg::*, mem_packet_pkg::*; (
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  logic [NUM_ENGINES-1:0] req_valid_i,
    input  logic [ADDR_W-1:0]      req_addr_i [NUM_ENGINES],
    input  logic                   mem_req_full_i,
    input  logic                   mem_rsp_valid_i,
    input  mem_word_u              mem_rsp_word_i,
    output logic [NUM_ENGINES-1:0] req_grant_o,
    output logic                   mem_req_valid_o,
    output mem_word_u              mem_req_word_o,
    output logic [NUM_ENGINES-1:0] rsp_valid_o,
    output logic [MEM_DATA_W-1:0]  rsp_data_o,
    output logic                   queue_empty_o
);

    // Next engine in line for the grant
    logic [ENGINE_ID_W-1:0] rr_ptr_q;
    logic [ENGINE_ID_W-1:0] grant_id;
    logic                   grant_hit;
    mem_word_u              req_word;
    logic                   q_full;
    logic                   q_pop;
    logic                   rsp_valid_q;
    mem_word_u              rsp_word_q;

    // ------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------
    // Walk from farthest to nearest so the engine at the pointer wins last
    always_comb begin
        int idx;
        grant_hit = 1'b0;
        grant_id  = '0;
        for (int i = NUM_ENGINES - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr_q) + i) % NUM_ENGINES;
            if (req_valid_i[idx] && !q_full) begin
                grant_hit = 1'b1;
                grant_id  = ENGINE_ID_W'(idx);
            end
        end
    end

    always_comb begin
        req_grant_o           = '0;
        req_grant_o[grant_id] = grant_hit;
    end

    // Tag the granted address with its engine
    always_comb begin
        req_word          = '0;
        req_word.req.id   = grant_id;
        req_word.req.addr = req_addr_i[grant_id];
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            rr_ptr_q <= '0;
        end else if (grant_hit) begin
            rr_ptr_q <= (grant_id == ENGINE_ID_W'(NUM_ENGINES - 1)) ? '0 : grant_id + 1'b1;
        end
    end

    // Granted word enters the queue in the grant cycle
    lane_fifo #(
        .WIDTH (MEM_WORD_W),
        .DEPTH (REQ_FIFO_DEPTH)
    ) u_req_fifo (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .push_i               (grant_hit),
        .push_data_i          (req_word),
        .pop_i                (q_pop),
        .pop_data_o           (mem_req_word_o),
        .empty_o              (queue_empty_o),
        .full_o               (q_full)
    );

    // Head leaves whenever memory is not full
    assign q_pop           = !queue_empty_o && !mem_req_full_i;
    assign mem_req_valid_o = q_pop;

    // ------------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= mem_rsp_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        rsp_word_q <= mem_rsp_word_i;
    end

    // One strobe per response, data shared by all engines
    always_comb begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            rsp_valid_o[i] = rsp_valid_q && (rsp_word_q.rsp.id == ENGINE_ID_W'(i));
        end
    end
    assign rsp_data_o = rsp_word_q.rsp.data;

    // Engine at the pointer has first claim on a free queue slot
    a_grant_ptr_first: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (req_valid_i[rr_ptr_q] && !q_full) |-> req_grant_o[rr_ptr_q]);
    // Memory echoes an ID that this arbiter issued
    a_rsp_id_range: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        mem_rsp_valid_i |-> (int'(mem_rsp_word_i.rsp.id) < NUM_ENGINES));

endmodule : mem_port_arbiter

`default_nettype wire

// ==== logic/lane_control.sv ====
// Lane control holding the kernel descriptor base and the drained flag
`timescale 1ns/10ps
`default_nettype none

module lane_control import lane_config_pkg::*; (
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  logic                   descriptor_valid_i,
    input  logic [ADDR_W-1:0]      descriptor_base_i,
    input  logic                   lane_in_valid_i,
    input  logic [NUM_ENGINES-1:0] engine_idle_i,
    input  logic                   queue_empty_i,
    output logic [ADDR_W-1:0]      base_o,
    output logic                   done_o
);

    // A descriptor has arrived since reset
    logic seen_q;

    // ------------------------------------------------------------------
    // Descriptor and done
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            seen_q <= 1'b0;
            done_o <= 1'b0;
        end else begin
            if (descriptor_valid_i) begin
                seen_q <= 1'b1;
            end
            // A push or a descriptor this cycle is not yet visible in the idle levels
            done_o <= seen_q && (&engine_idle_i) && queue_empty_i
                      && !lane_in_valid_i && !descriptor_valid_i;
        end
    end

    // Base broadcast to every engine
    always_ff @(posedge ap_clk) begin
        if (descriptor_valid_i) begin
            base_o <= descriptor_base_i;
        end
    end

endmodule : lane_control

`default_nettype wire

// ==== logic/lane_top.sv ====
// Lane top with the engine chain, the shared memory port arbiter and lane control
`timescale 1ns/10ps
`default_nettype none

module lane_top import lane_config_pkg::*, mem_packet_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_lane_template,
    input  logic               descriptor_valid_i,
    input  logic [ADDR_W-1:0]  descriptor_base_i,
    input  logic               lane_in_valid_i,
    input  logic [VALUE_W-1:0] lane_in_value_i,
    output logic               lane_in_full_o,
    output logic               lane_out_valid_o,
    output logic [VALUE_W-1:0] lane_out_value_o,
    input  logic               lane_out_full_i,
    output logic               mem_req_valid_o,
    output mem_word_u          mem_req_word_o,
    input  logic               mem_req_full_i,
    input  logic               mem_rsp_valid_i,
    input  mem_word_u          mem_rsp_word_i,
    output logic               done_o
);

    // Chain links, index k feeds engine k, the last one is the lane output
    logic                   chain_valid [NUM_ENGINES+1];
    logic [VALUE_W-1:0]     chain_value [NUM_ENGINES+1];
    logic                   chain_full  [NUM_ENGINES+1];
    logic [ADDR_W-1:0]      base;
    logic [NUM_ENGINES-1:0] req_valid;
    logic [ADDR_W-1:0]      req_addr [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] req_grant;
    logic [NUM_ENGINES-1:0] rsp_valid;
    logic [MEM_DATA_W-1:0]  rsp_data;
    logic [NUM_ENGINES-1:0] engine_idle;
    logic                   queue_empty;

    // ------------------------------------------------------------------
    // Chain ends
    // ------------------------------------------------------------------
    assign chain_valid[0]           = lane_in_valid_i;
    assign chain_value[0]           = lane_in_value_i;
    assign lane_in_full_o           = chain_full[0];
    assign lane_out_valid_o         = chain_valid[NUM_ENGINES];
    assign lane_out_value_o         = chain_value[NUM_ENGINES];
    assign chain_full[NUM_ENGINES]  = lane_out_full_i;

    lane_control u_control (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .descriptor_valid_i   (descriptor_valid_i),
        .descriptor_base_i    (descriptor_base_i),
        .lane_in_valid_i      (lane_in_valid_i),
        .engine_idle_i        (engine_idle),
        .queue_empty_i        (queue_empty),
        .base_o               (base),
        .done_o               (done_o)
    );

    // ------------------------------------------------------------------
    // Engines, next engine's full level is this one's back-pressure
    // ------------------------------------------------------------------
    for (genvar k = 0; k < NUM_ENGINES; k++) begin : g_engine
        lane_engine #(
            .ENGINE_ID (k)
        ) u_engine (
            .ap_clk               (ap_clk),
            .areset_lane_template (areset_lane_template),
            .in_push_i            (chain_valid[k]),
            .in_value_i           (chain_value[k]),
            .base_i               (base),
            .req_grant_i          (req_grant[k]),
            .rsp_valid_i          (rsp_valid[k]),
            .rsp_data_i           (rsp_data),
            .out_full_i           (chain_full[k+1]),
            .in_full_o            (chain_full[k]),
            .req_valid_o          (req_valid[k]),
            .req_addr_o           (req_addr[k]),
            .out_valid_o          (chain_valid[k+1]),
            .out_value_o          (chain_value[k+1]),
            .idle_o               (engine_idle[k])
        );
    end

    mem_port_arbiter u_arbiter (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .req_valid_i          (req_valid),
        .req_addr_i           (req_addr),
        .mem_req_full_i       (mem_req_full_i),
        .mem_rsp_valid_i      (mem_rsp_valid_i),
        .mem_rsp_word_i       (mem_rsp_word_i),
        .req_grant_o          (req_grant),
        .mem_req_valid_o      (mem_req_valid_o),
        .mem_req_word_o       (mem_req_word_o),
        .rsp_valid_o          (rsp_valid),
        .rsp_data_o           (rsp_data),
        .queue_empty_o        (queue_empty)
    );

endmodule : lane_top

`default_nettype wire

// ==== include/lane_tb_tasks.svh ====
// Directed lane tests with the chain reference model and the in-order output check
`ifndef LANE_TB_TASKS_SVH
`define LANE_TB_TASKS_SVH

// ----------------------------------------------------------------------
// Reference model
// ----------------------------------------------------------------------
// Each stage reads at base + value, then adds the word it read
function automatic logic [VALUE_W-1:0] lane_model(input logic [VALUE_W-1:0] value,
                                                  input logic [ADDR_W-1:0]  base);
    logic [VALUE_W-1:0] v;
    logic [ADDR_W-1:0]  addr;
    v = value;
    for (int k = 0; k < NUM_ENGINES; k++) begin
        addr = base + ADDR_W'(v);
        // Memory contents are the address scrambled with the fill pattern
        v    = v + VALUE_W'(addr ^ MEM_PATTERN);
    end
    return v;
endfunction

// Outputs must come back in push order
task automatic check_output(input logic [VALUE_W-1:0] got);
    logic [VALUE_W-1:0] exp;
    assert (expected_q.size() != 0)
        else fail_check($sformatf("lane output %h with nothing outstanding", got));
    exp = expected_q.pop_front();
    assert (got == exp)
        else fail_check($sformatf("lane output %h, expected %h", got, exp));
endtask

// ----------------------------------------------------------------------
// Stimulus helpers
// ----------------------------------------------------------------------
task automatic send_descriptor(input logic [ADDR_W-1:0] base);
    @(posedge ap_clk);
    descriptor_valid <= 1'b1;
    descriptor_base  <= base;
    model_base       = base;
    @(posedge ap_clk);
    descriptor_valid <= 1'b0;
endtask

// One idle cycle between pushes, so the sampled full level is never stale
task automatic push_value(input logic [VALUE_W-1:0] value);
    @(posedge ap_clk);
    while (lane_in_full) begin
        @(posedge ap_clk);
    end
    lane_in_valid <= 1'b1;
    lane_in_value <= value;
    expected_q.push_back(lane_model(value, model_base));
    @(posedge ap_clk);
    lane_in_valid <= 1'b0;
endtask

task automatic push_random_values(input int count);
    integer rnd;
    for (int n = 0; n < count; n++) begin
        rnd = $random(stim_seed);
        push_value(rnd[VALUE_W-1:0]);
    end
endtask

// Watchdog bounds both waits
task automatic wait_drained();
    while (expected_q.size() != 0) begin
        @(posedge ap_clk);
    end
endtask

task automatic wait_done();
    while (!done) begin
        @(posedge ap_clk);
    end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic check_reset_state();
    @(posedge ap_clk);
    assert (!lane_out_valid) else fail_check("lane output valid after reset");
    assert (!mem_req_valid) else fail_check("memory request valid after reset");
    assert (!done) else fail_check("done high after reset");
    assert (!lane_in_full) else fail_check("lane input full after reset");
endtask

task automatic run_single_value();
    send_descriptor(BASE_A);
    push_value(16'h0013);
    wait_drained();
endtask

task automatic stream_under_out_stall();
    out_full_en <= 1'b1;
    push_random_values(32);
    wait_drained();
    out_full_en <= 1'b0;
endtask

task automatic stream_under_mem_stall();
    req_full_en <= 1'b1;
    push_random_values(32);
    wait_drained();
    req_full_en <= 1'b0;
endtask

// Drained lane reports done, a new base clears it for one more batch
task automatic done_then_rebase();
    wait_done();
    send_descriptor(BASE_B);
    @(posedge ap_clk);
    assert (!done) else fail_check("done still high after a new descriptor");
    push_random_values(8);
    wait_drained();
    wait_done();
endtask

`endif

// ==== dv/lane_tb.sv ====
// Lane testbench with clock, reset, memory responder, back-pressure and watchdog
`timescale 1ns/10ps
`default_nettype none

module lane_tb import lane_config_pkg::*, mem_packet_pkg::*; ();

    localparam int                    CLK_PERIOD   = 40;
    localparam int                    RESET_CYCLES = 16;
    localparam logic [31:0]           RAND_SEED    = 32'he30b_1cba;
    localparam logic [MEM_DATA_W-1:0] MEM_PATTERN  = 16'h5a3c;
    localparam logic [ADDR_W-1:0]     BASE_A       = 16'h1200;
    localparam logic [ADDR_W-1:0]     BASE_B       = 16'h0a5c;
    // All values pushed by the tests, each given a generous cycle budget
    localparam int TOTAL_VALUES     = 73;
    localparam int CYCLES_PER_VALUE = 256;
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + TOTAL_VALUES * CYCLES_PER_VALUE + 1296;

    logic               ap_clk;
    logic               areset_lane_template;
    logic               descriptor_valid;
    logic [ADDR_W-1:0]  descriptor_base;
    logic               lane_in_valid;
    logic [VALUE_W-1:0] lane_in_value;
    logic               lane_in_full;
    logic               lane_out_valid;
    logic [VALUE_W-1:0] lane_out_value;
    logic               lane_out_full = 1'b0;
    logic               mem_req_valid;
    mem_word_u          mem_req_word;
    logic               mem_req_full  = 1'b0;
    logic               mem_rsp_valid = 1'b0;
    mem_word_u          mem_rsp_word  = '0;
    logic               done;

    // Scoreboard and memory model state
    logic [VALUE_W-1:0]     expected_q [$];
    mem_word_u              pending_q  [$];
    // Engines with a request that memory has not answered yet
    logic [NUM_ENGINES-1:0] id_busy      = '0;
    logic [ADDR_W-1:0]      model_base;
    logic                   out_full_en  = 1'b0;
    logic                   req_full_en  = 1'b0;
    integer                 stim_seed    = RAND_SEED;
    integer                 env_seed;
    int                     cycle_count  = 0;
    int                     rsp_gap      = 0;
    int                     out_full_len = 0;
    int                     req_full_len = 0;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_check(input string msg);
        stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    `include "lane_tb_tasks.svh"

    lane_top dut0 (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .descriptor_valid_i   (descriptor_valid),
        .descriptor_base_i    (descriptor_base),
        .lane_in_valid_i      (lane_in_valid),
        .lane_in_value_i      (lane_in_value),
        .lane_in_full_o       (lane_in_full),
        .lane_out_valid_o     (lane_out_valid),
        .lane_out_value_o     (lane_out_value),
        .lane_out_full_i      (lane_out_full),
        .mem_req_valid_o      (mem_req_valid),
        .mem_req_word_o       (mem_req_word),
        .mem_req_full_i       (mem_req_full),
        .mem_rsp_valid_i      (mem_rsp_valid),
        .mem_rsp_word_i       (mem_rsp_word),
        .done_o               (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // Watchdog
    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout, the tests did not end within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    // ------------------------------------------------------------------
    // Memory responder, back-pressure and output monitor
    // ------------------------------------------------------------------
    always @(posedge ap_clk) begin
        mem_word_u req_word;
        mem_word_u rsp_word;
        integer    rnd;
        if (areset_lane_template) begin
            mem_rsp_valid <= 1'b0;
            lane_out_full <= 1'b0;
            mem_req_full  <= 1'b0;
        end else begin
            if (mem_req_valid) begin
                assert (!mem_req_full) else fail_check("request issued while memory full");
                // Each engine keeps at most one request in flight
                assert (!id_busy[mem_req_word.req.id])
                    else fail_check($sformatf("request ID %0d issued while one is outstanding",
                                              mem_req_word.req.id));
                id_busy[mem_req_word.req.id] = 1'b1;
                pending_q.push_back(mem_req_word);
            end
            // Answer in request order after a random gap
            mem_rsp_valid <= 1'b0;
            if (rsp_gap > 0) begin
                rsp_gap = rsp_gap - 1;
            end else if (pending_q.size() != 0) begin
                req_word          = pending_q.pop_front();
                id_busy[req_word.req.id] = 1'b0;
                rsp_word.rsp.id   = req_word.req.id;
                rsp_word.rsp.data = req_word.req.addr ^ MEM_PATTERN;
                mem_rsp_word  <= rsp_word;
                mem_rsp_valid <= 1'b1;
                rnd     = $random(env_seed);
                rsp_gap = rnd & 7;
            end
            // Random level held for a random stretch
            if (!out_full_en) begin
                lane_out_full <= 1'b0;
            end else if (out_full_len == 0) begin
                rnd           = $random(env_seed);
                lane_out_full <= rnd[0];
                out_full_len  = 1 + int'(rnd[7:4]);
            end else begin
                out_full_len = out_full_len - 1;
            end
            if (!req_full_en) begin
                mem_req_full <= 1'b0;
            end else if (req_full_len == 0) begin
                rnd          = $random(env_seed);
                mem_req_full <= rnd[0];
                req_full_len = 1 + int'(rnd[7:4]);
            end else begin
                req_full_len = req_full_len - 1;
            end
            if (lane_out_valid) begin
                assert (!lane_out_full) else fail_check("lane output fired while full");
                check_output(lane_out_value);
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        env_seed             = $random(stim_seed);
        model_base           = '0;
        areset_lane_template = 1'b1;
        descriptor_valid     = 1'b0;
        descriptor_base      = '0;
        lane_in_valid        = 1'b0;
        lane_in_value        = '0;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_lane_template <= 1'b0;
        check_reset_state();
        run_single_value();
        stream_under_out_stall();
        stream_under_mem_stall();
        done_then_rebase();
        @(posedge ap_clk);
        if (expected_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("Lane outputs are missing at the end of the run");
        end
    end

endmodule : lane_tb

`default_nettype wire

// ==== all.f ====
+incdir+include
logic/lane_config_pkg.sv
logic/mem_packet_pkg.sv
logic/lane_fifo.sv
logic/lane_engine.sv
logic/mem_port_arbiter.sv
logic/lane_control.sv
logic/lane_top.sv
dv/lane_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the lane testbench with Verilator and run it

cd "$(dirname "$0")"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Cannot enter the project root"
    exit "$status"
fi

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module lane_tb -f all.f --Mdir obj_dir -o lane_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/lane_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
